// ==== mcu8_pkg.sv ====
package mcu8_pkg;

   //////////////////////////////
   // widths
   localparam int data_w     = 8;
   localparam int instr_w    = 18;
   localparam int pc_w       = 12;
   localparam int reg_addr_w = 4;

   //////////////////////////////
   // instruction word fields
   localparam int op_msb         = 17;   // opcode field 17:12
   localparam int op_lsb         = 12;
   localparam int cond_bit       = 16;   // set on conditional branches
   localparam int cond_msb       = 15;   // 00 z, 01 nz, 10 c, 11 nc
   localparam int cond_lsb       = 14;
   localparam int cy_sel_bit     = 13;   // addcy, subcy, testcy, comparecy
   localparam int k_sel_bit      = 12;   // second operand is the constant
   localparam int sx_msb         = 11;
   localparam int sx_lsb         = 8;
   localparam int sy_msb         = 7;
   localparam int sy_lsb         = 4;
   localparam int k_msb          = 7;
   localparam int shift_type_bit = 7;    // must be 0 for shift/rotate
   localparam int shift_msb      = 3;    // shift form in 3:0

   // decoded operations
   typedef enum logic [3:0] {
      op_nop, op_load, op_and, op_or, op_xor,
      op_add, op_sub, op_test, op_compare, op_shift,
      op_input, op_output, op_jump, op_call, op_return
   } opcode_e;

   // shift and rotate forms
   typedef enum logic [3:0] {
      sl0, sl1, slx, sla, rl,
      sr0, sr1, srx, sra, rr
   } shift_e;

   // branch conditions
   typedef enum logic [2:0] {
      cond_always, if_z, if_nz, if_c, if_nc
   } cond_e;

endpackage

// ==== mcu8_sequencer.sv ====
`timescale 1ns/10ps

module mcu8_sequencer #(
   parameter int stack_depth = 30
) (
   input  logic                      clk,
   input  logic                      rst,
   input  mcu8_pkg::opcode_e         opcode,
   input  mcu8_pkg::cond_e           cond,
   input  logic [mcu8_pkg::pc_w-1:0] target,
   input  logic                      z_flag,
   input  logic                      c_flag,
   output logic [mcu8_pkg::pc_w-1:0] address,
   output logic                      decode_phase,
   output logic                      execute_phase,
   output logic                      restart
);
   import mcu8_pkg::*;

   localparam int sp_w  = $clog2(stack_depth + 1);
   localparam int idx_w = (stack_depth > 1) ? $clog2(stack_depth) : 1;

   logic [pc_w-1:0]  pc;
   logic [pc_w-1:0]  next_pc;
   logic [pc_w-1:0]  stack [stack_depth];   // return addresses
   logic [sp_w-1:0]  sp;                    // entries in use
   logic [idx_w-1:0] push_idx;
   logic [idx_w-1:0] pop_idx;
   logic             cond_true;
   logic             do_jump;
   logic             do_call;
   logic             do_return;
   logic             stack_fault;

   //////////////////////////////
   // branch resolution
   always_comb
   begin
      case (cond)
         if_z:    cond_true = z_flag;
         if_nz:   cond_true = ~z_flag;
         if_c:    cond_true = c_flag;
         if_nc:   cond_true = ~c_flag;
         default: cond_true = 1'b1;
      endcase
   end

   assign do_jump   = (opcode == op_jump) && cond_true;
   assign do_call   = (opcode == op_call) && cond_true;
   assign do_return = (opcode == op_return) && cond_true;

   // full stack on a call, empty stack on a return
   assign stack_fault = (do_call && (sp == sp_w'(stack_depth))) ||
                        (do_return && (sp == '0));

   assign next_pc  = pc + 1'b1;
   assign push_idx = sp[idx_w-1:0];
   assign pop_idx  = idx_w'(sp - 1'b1);

   assign address       = pc;
   assign execute_phase = decode_phase & ~stack_fault;   // faulting op is not executed

   //////////////////////////////
   // phase, pc and stack pointer
   always_ff @(posedge clk)
   begin
      if (rst || restart)
      begin
         pc           <= '0;
         sp           <= '0;
         decode_phase <= 1'b0;
         restart      <= 1'b0;
      end
      else
      begin
         decode_phase <= ~decode_phase;
         restart      <= decode_phase & stack_fault;
         if (execute_phase)
         begin
            if (do_call)
            begin
               sp <= sp + 1'b1;
               pc <= target;
            end
            else if (do_return)
            begin
               sp <= sp - 1'b1;
               pc <= stack[pop_idx];
            end
            else if (do_jump)
               pc <= target;
            else
               pc <= next_pc;
         end
      end
   end

   // return address push
   always_ff @(posedge clk)
   begin
      if (execute_phase && do_call)
         stack[push_idx] <= next_pc;
   end

endmodule

// ==== mcu8_decode.sv ====
`timescale 1ns/10ps

module mcu8_decode (
   input  logic [mcu8_pkg::instr_w-1:0]    instruction,
   output mcu8_pkg::opcode_e               opcode,
   output mcu8_pkg::shift_e                shift_kind,
   output mcu8_pkg::cond_e                 cond,
   output logic                            use_const,
   output logic                            with_carry,
   output logic [mcu8_pkg::reg_addr_w-1:0] sx_addr,
   output logic [mcu8_pkg::reg_addr_w-1:0] sy_addr,
   output logic [mcu8_pkg::data_w-1:0]     constant,
   output logic [mcu8_pkg::pc_w-1:0]       target
);
   import mcu8_pkg::*;

   logic [op_msb-op_lsb:0] op_field;
   logic                   shift_ok;

   assign op_field = instruction[op_msb:op_lsb];

   // shift form from the low nibble
   always_comb
   begin
      shift_kind = sl0;
      shift_ok   = 1'b1;
      case (instruction[shift_msb:0])
         4'b0110: shift_kind = sl0;
         4'b0111: shift_kind = sl1;
         4'b0100: shift_kind = slx;
         4'b0000: shift_kind = sla;
         4'b0010: shift_kind = rl;
         4'b1110: shift_kind = sr0;
         4'b1111: shift_kind = sr1;
         4'b1010: shift_kind = srx;
         4'b1000: shift_kind = sra;
         4'b1100: shift_kind = rr;
         default: shift_ok   = 1'b0;
      endcase
      if (instruction[shift_type_bit])
         shift_ok = 1'b0;                  // hwbuild slot
   end

   //////////////////////////////
   // opcode map
   always_comb
   begin
      opcode = op_nop;                     // anything unlisted
      casez (op_field)
         6'b00000?: opcode = op_load;
         6'b00001?: opcode = op_and;
         6'b00010?: opcode = op_or;
         6'b00011?: opcode = op_xor;
         6'b00100?: opcode = op_input;
         6'b0011??: opcode = op_test;
         6'b0100??: opcode = op_add;
         6'b0110??: opcode = op_sub;
         6'b0111??: opcode = op_compare;
         6'b010100: opcode = shift_ok ? op_shift : op_nop;
         6'b10110?: opcode = op_output;
         6'b100010,
         6'b11??10: opcode = op_jump;
         6'b100000,
         6'b11??00: opcode = op_call;
         6'b100101,
         6'b11??01: opcode = op_return;
         default:   opcode = op_nop;
      endcase
   end

   // branch condition
   always_comb
   begin
      cond = cond_always;
      if (instruction[op_msb] && instruction[cond_bit])
      begin
         case (instruction[cond_msb:cond_lsb])
            2'b00:   cond = if_z;
            2'b01:   cond = if_nz;
            2'b10:   cond = if_c;
            default: cond = if_nc;
         endcase
      end
   end

   assign use_const  = instruction[k_sel_bit];
   assign with_carry = instruction[cy_sel_bit] &&
                       (opcode inside {op_add, op_sub, op_test, op_compare});

   assign sx_addr  = instruction[sx_msb:sx_lsb];
   assign sy_addr  = instruction[sy_msb:sy_lsb];
   assign constant = instruction[k_msb:0];
   assign target   = instruction[pc_w-1:0];

endmodule

// ==== mcu8_regfile.sv ====
`timescale 1ns/10ps

module mcu8_regfile (
   input  logic                            clk,
   input  logic [mcu8_pkg::reg_addr_w-1:0] rd_addr_a,
   input  logic [mcu8_pkg::reg_addr_w-1:0] rd_addr_b,
   output logic [mcu8_pkg::data_w-1:0]     rd_data_a,
   output logic [mcu8_pkg::data_w-1:0]     rd_data_b,
   input  logic                            wr_en,
   input  logic [mcu8_pkg::reg_addr_w-1:0] wr_addr,
   input  logic [mcu8_pkg::data_w-1:0]     wr_data
);
   import mcu8_pkg::*;

   localparam int num_regs = 1 << reg_addr_w;

   // s0..sF, power-up zero
   logic [data_w-1:0] regs [num_regs] = '{default: '0};

   // asynchronous reads, sx and sy
   assign rd_data_a = regs[rd_addr_a];
   assign rd_data_b = regs[rd_addr_b];

   always_ff @(posedge clk)
   begin
      if (wr_en)
         regs[wr_addr] <= wr_data;
   end

endmodule

// ==== mcu8_execute.sv ====
`timescale 1ns/10ps

module mcu8_execute (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            restart,
   input  logic                            execute_phase,
   input  mcu8_pkg::opcode_e               opcode,
   input  mcu8_pkg::shift_e                shift_kind,
   input  logic                            use_const,
   input  logic                            with_carry,
   input  logic [mcu8_pkg::reg_addr_w-1:0] sx_addr,
   input  logic [mcu8_pkg::data_w-1:0]     constant,
   input  logic [mcu8_pkg::data_w-1:0]     sx_data,
   input  logic [mcu8_pkg::data_w-1:0]     sy_data,
   input  logic [mcu8_pkg::data_w-1:0]     in_port,
   output logic                            wr_en,
   output logic [mcu8_pkg::reg_addr_w-1:0] wr_addr,
   output logic [mcu8_pkg::data_w-1:0]     wr_data,
   output logic                            z_flag,
   output logic                            c_flag,
   output logic [mcu8_pkg::data_w-1:0]     out_port,
   output logic [mcu8_pkg::data_w-1:0]     port_id,
   output logic                            read_strobe,
   output logic                            write_strobe
);
   import mcu8_pkg::*;

   logic [data_w-1:0]     operand_b;
   logic [data_w-1:0]     alu_res;
   logic                  alu_carry;
   logic                  cin;
   logic                  shift_in;
   opcode_e               op_q;          // op_nop outside the execute cycle
   logic                  with_carry_q;
   logic [data_w-1:0]     res_q;
   logic                  carry_q;
   logic [reg_addr_w-1:0] sx_addr_q;
   logic                  flag_op;

   assign operand_b = use_const ? constant : sy_data;
   assign cin       = c_flag & with_carry;

   // bit shifted in
   always_comb
   begin
      case (shift_kind)
         sl1, sr1: shift_in = 1'b1;
         slx, rr:  shift_in = sx_data[0];
         rl, srx:  shift_in = sx_data[data_w-1];
         sla, sra: shift_in = c_flag;
         default:  shift_in = 1'b0;
      endcase
   end

   //////////////////////////////
   // alu
   always_comb
   begin
      alu_res   = operand_b;                  // load
      alu_carry = 1'b0;
      case (opcode)
         op_and: alu_res = sx_data & operand_b;
         op_or:  alu_res = sx_data | operand_b;
         op_xor: alu_res = sx_data ^ operand_b;
         op_test:
         begin
            alu_res   = sx_data & operand_b;
            alu_carry = ^{alu_res, cin};      // odd parity, testcy folds in C
         end
         op_add:
            {alu_carry, alu_res} = {1'b0, sx_data} + {1'b0, operand_b} + {{data_w{1'b0}}, cin};
         op_sub, op_compare:
            {alu_carry, alu_res} = {1'b0, sx_data} - {1'b0, operand_b} - {{data_w{1'b0}}, cin};
         op_shift:
            if (shift_kind inside {sr0, sr1, srx, sra, rr})
               {alu_res, alu_carry} = {shift_in, sx_data};
            else
               {alu_carry, alu_res} = {sx_data, shift_in};
         default: ;
      endcase
   end

   // operand latch at the end of decode
   always_ff @(posedge clk)
   begin
      if (execute_phase)
      begin
         res_q        <= alu_res;
         carry_q      <= alu_carry;
         with_carry_q <= with_carry;
         sx_addr_q    <= sx_addr;
         port_id      <= operand_b;
         out_port     <= sx_data;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst || restart)
      begin
         op_q         <= op_nop;
         read_strobe  <= 1'b0;
         write_strobe <= 1'b0;
      end
      else
      begin
         op_q         <= execute_phase ? opcode : op_nop;
         read_strobe  <= execute_phase && (opcode == op_input);
         write_strobe <= execute_phase && (opcode == op_output);
      end
   end

   //////////////////////////////
   // write back, execute cycle
   assign wr_en   = op_q inside {op_load, op_and, op_or, op_xor, op_add, op_sub,
                                 op_shift, op_input};
   assign wr_addr = sx_addr_q;
   assign wr_data = (op_q == op_input) ? in_port : res_q;   // in_port sampled here
   assign flag_op = op_q inside {op_and, op_or, op_xor, op_add, op_sub, op_test,
                                 op_compare, op_shift};

   always_ff @(posedge clk)
   begin
      if (rst || restart)
      begin
         z_flag <= 1'b0;
         c_flag <= 1'b0;
      end
      else if (flag_op)
      begin
         c_flag <= carry_q;
         z_flag <= (res_q == '0) & (z_flag | ~with_carry_q);   // cy forms chain Z
      end
   end

endmodule

// ==== mcu8.sv ====
`timescale 1ns/10ps

module mcu8 #(
   parameter int stack_depth = 30
) (
   input  logic                         clk,
   input  logic                         rst,
   output logic [mcu8_pkg::pc_w-1:0]    address,
   input  logic [mcu8_pkg::instr_w-1:0] instruction,
   input  logic [mcu8_pkg::data_w-1:0]  in_port,
   output logic [mcu8_pkg::data_w-1:0]  out_port,
   output logic [mcu8_pkg::data_w-1:0]  port_id,
   output logic                         read_strobe,
   output logic                         write_strobe
);
   import mcu8_pkg::*;

   // phases
   logic decode_phase;
   logic execute_phase;
   logic restart;

   // decoded fields
   opcode_e               opcode;
   shift_e                shift_kind;
   cond_e                 cond;
   logic                  use_const;
   logic                  with_carry;
   logic [reg_addr_w-1:0] sx_addr;
   logic [reg_addr_w-1:0] sy_addr;
   logic [data_w-1:0]     constant;
   logic [pc_w-1:0]       target;

   // register file and flags
   logic [data_w-1:0]     sx_data;
   logic [data_w-1:0]     sy_data;
   logic                  wr_en;
   logic [reg_addr_w-1:0] wr_addr;
   logic [data_w-1:0]     wr_data;
   logic                  z_flag;
   logic                  c_flag;

   //////////////////////////////
   mcu8_sequencer #(
      .stack_depth(stack_depth)
   ) u_sequencer (
      .clk          (clk),
      .rst          (rst),
      .opcode       (opcode),
      .cond         (cond),
      .target       (target),
      .z_flag       (z_flag),
      .c_flag       (c_flag),
      .address      (address),
      .decode_phase (decode_phase),
      .execute_phase(execute_phase),
      .restart      (restart)
   );

   mcu8_decode u_decode (
      .instruction(instruction),
      .opcode     (opcode),
      .shift_kind (shift_kind),
      .cond       (cond),
      .use_const  (use_const),
      .with_carry (with_carry),
      .sx_addr    (sx_addr),
      .sy_addr    (sy_addr),
      .constant   (constant),
      .target     (target)
   );

   mcu8_regfile u_regfile (
      .clk      (clk),
      .rd_addr_a(sx_addr),
      .rd_addr_b(sy_addr),
      .rd_data_a(sx_data),
      .rd_data_b(sy_data),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data)
   );

   mcu8_execute u_execute (
      .clk          (clk),
      .rst          (rst),
      .restart      (restart),
      .execute_phase(execute_phase),
      .opcode       (opcode),
      .shift_kind   (shift_kind),
      .use_const    (use_const),
      .with_carry   (with_carry),
      .sx_addr      (sx_addr),
      .constant     (constant),
      .sx_data      (sx_data),
      .sy_data      (sy_data),
      .in_port      (in_port),
      .wr_en        (wr_en),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .z_flag       (z_flag),
      .c_flag       (c_flag),
      .out_port     (out_port),
      .port_id      (port_id),
      .read_strobe  (read_strobe),
      .write_strobe (write_strobe)
   );

endmodule

// ==== mcu8_props.sv ====
`timescale 1ns/10ps

module mcu8_props (
   input logic clk,
   input logic rst,
   input logic read_strobe,
   input logic write_strobe
);

   //////////////////////////////
   // port strobes
   strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
      !(read_strobe && write_strobe))
      else $error("read_strobe and write_strobe high together");

   read_one_cycle: assert property (@(posedge clk) disable iff (rst)
      read_strobe |=> !read_strobe)
      else $error("read_strobe held longer than one cycle");

   write_one_cycle: assert property (@(posedge clk) disable iff (rst)
      write_strobe |=> !write_strobe)
      else $error("write_strobe held longer than one cycle");

   // quiet port after reset
   strobes_low_after_rst: assert property (@(posedge clk)
      rst |=> (!read_strobe && !write_strobe))
      else $error("strobe high in the cycle after rst");

endmodule

bind mcu8_execute mcu8_props u_props (
   .clk         (clk),
   .rst         (rst),
   .read_strobe (read_strobe),
   .write_strobe(write_strobe)
);

// ==== mcu8_tb.sv ====
`timescale 1ns/10ps

module mcu8_tb;

   localparam int stack_depth = 30;
   localparam int max_steps   = 20000;
   localparam logic [11:0] sub_a = 12'h300;
   localparam logic [11:0] sub_b = 12'h310;
   localparam logic [11:0] sub_c = 12'h318;
   localparam logic [11:0] rec   = 12'h320;

   logic        clk;
   logic        rst;
   logic [11:0] address;
   logic [17:0] instruction;
   logic [7:0]  in_port;
   logic [7:0]  out_port;
   logic [7:0]  port_id;
   logic        read_strobe;
   logic        write_strobe;

   logic [17:0] rom [4096];
   logic [7:0]  in_seq [64];
   logic [5:0]  in_idx;
   logic [11:0] asm_pc;
   logic [11:0] halt_addr;
   int          errors;
   int          exec_count;
   int          cycle_limit;

   // expected port events, in order
   bit          exp_is_out [$];
   logic [7:0]  exp_port [$];
   logic [7:0]  exp_data [$];

   mcu8 #(
      .stack_depth(stack_depth)
   ) i_mcu8 (
      .clk         (clk),
      .rst         (rst),
      .address     (address),
      .instruction (instruction),
      .in_port     (in_port),
      .out_port    (out_port),
      .port_id     (port_id),
      .read_strobe (read_strobe),
      .write_strobe(write_strobe)
   );

   always #10 clk = ~clk;

   //////////////////////////////
   // program assembly
   task automatic place_word(input logic [17:0] w);
      rom[asm_pc] = w;
      asm_pc      = asm_pc + 12'd1;
   endtask

   task automatic op_const(input logic [5:0] op, input logic [3:0] sx, input logic [7:0] k);
      place_word({op, sx, k});
   endtask

   task automatic op_reg(input logic [5:0] op, input logic [3:0] sx, input logic [3:0] sy);
      place_word({op, sx, sy, 4'h0});
   endtask

   task automatic branch_to(input logic [5:0] op, input logic [11:0] dest);
      place_word({op, dest});
   endtask

   // carry into sx via addcy of zeros
   task automatic capture_carry(input logic [3:0] sx);
      op_const(6'h01, sx, 8'h00);
      op_const(6'h13, sx, 8'h00);
   endtask

   task automatic alu_block(input logic [7:0] pb);
      op_const(6'h01, 4'h0, 8'($urandom));
      op_const(6'h01, 4'h1, 8'($urandom));
      op_const(6'h01, 4'h2, 8'($urandom));
      op_reg(6'h00, 4'h3, 4'h0);
      op_reg(6'h02, 4'h3, 4'h1);               // and
      op_const(6'h2D, 4'h3, pb);
      op_reg(6'h00, 4'h3, 4'h0);
      op_const(6'h05, 4'h3, 8'($urandom));     // or k
      op_const(6'h2D, 4'h3, pb + 8'd1);
      op_reg(6'h00, 4'h3, 4'h0);
      op_reg(6'h06, 4'h3, 4'h2);               // xor
      op_const(6'h2D, 4'h3, pb + 8'd2);
      op_reg(6'h10, 4'h0, 4'h1);               // add then addcy
      op_const(6'h13, 4'h2, 8'($urandom));
      capture_carry(4'h4);
      op_const(6'h2D, 4'h0, pb + 8'd3);
      op_const(6'h2D, 4'h2, pb + 8'd4);
      op_const(6'h2D, 4'h4, pb + 8'd5);
      op_const(6'h19, 4'h1, 8'($urandom));     // sub then subcy
      op_reg(6'h1A, 4'h2, 4'h0);
      capture_carry(4'h4);
      op_const(6'h2D, 4'h1, pb + 8'd6);
      op_const(6'h2D, 4'h2, pb + 8'd7);
      op_const(6'h2D, 4'h4, pb + 8'd8);
   endtask

   task automatic shift_block();
      logic [3:0] codes [10];
      codes = '{4'h6, 4'h7, 4'h4, 4'h0, 4'h2, 4'hE, 4'hF, 4'hA, 4'h8, 4'hC};
      for (int i = 0; i < 10; i++)
      begin
         op_const(6'h01, 4'h5, 8'($urandom));
         op_const(6'h1D, 4'h5, 8'($urandom));  // random carry for sla, sra
         place_word({6'h14, 4'h5, 4'h0, codes[i]});
         capture_carry(4'h6);
         op_const(6'h2D, 4'h5, 8'h80 + 8'(i));
         op_const(6'h2D, 4'h6, 8'h90 + 8'(i));
      end
   endtask

   // taken branch skips the output
   task automatic jump_block();
      logic [5:0] jumps [4];
      logic [7:0] a;
      logic [7:0] k;
      jumps = '{6'h32, 6'h36, 6'h3A, 6'h3E};
      for (int i = 0; i < 16; i++)
      begin
         a = 8'($urandom);
         k = i[2] ? a : 8'($urandom);
         op_const(6'h01, 4'h7, a);
         op_const((i < 8) ? 6'h1D : 6'h0D, 4'h7, k);
         branch_to(jumps[i % 4], asm_pc + 12'd2);
         op_const(6'h2D, 4'h7, 8'h40 + 8'(i));
      end
   endtask

   task automatic build_program();
      for (int a = 0; a < 4096; a++)
         rom[a] = {6'h22, 12'(a)};               // jump to self
      asm_pc = 12'h000;
      op_const(6'h11, 4'hF, 8'h01);              // pass counter, survives restart
      alu_block(8'h00);
      alu_block(8'h10);
      alu_block(8'h20);
      shift_block();
      jump_block();
      op_reg(6'h1C, 4'h0, 4'h0);                 // z set
      branch_to(6'h34, sub_a);
      branch_to(6'h20, sub_a);
      op_const(6'h2D, 4'h3, 8'h54);
      branch_to(6'h30, sub_c);
      op_const(6'h2D, 4'h8, 8'h55);
      op_const(6'h09, 4'h9, 8'h60);              // input tests
      op_const(6'h2D, 4'h9, 8'h61);
      op_const(6'h01, 4'hA, 8'h62);
      op_reg(6'h08, 4'hB, 4'hA);
      op_reg(6'h2C, 4'hB, 4'hA);
      op_reg(6'h10, 4'hB, 4'h9);
      op_const(6'h2D, 4'hB, 8'h63);
      op_const(6'h1D, 4'hF, 8'h02);              // second pass skips recursion
      branch_to(6'h3E, asm_pc + 12'd2);
      branch_to(6'h20, rec);
      halt_addr = asm_pc;
      branch_to(6'h22, asm_pc);
      asm_pc = sub_a;
      op_const(6'h2D, 4'h0, 8'h50);
      branch_to(6'h20, sub_b);
      op_const(6'h2D, 4'h1, 8'h51);
      branch_to(6'h25, 12'h000);
      asm_pc = sub_b;
      op_const(6'h2D, 4'h2, 8'h52);
      op_reg(6'h1C, 4'h2, 4'h2);
      branch_to(6'h31, 12'h000);                 // return z, taken
      op_const(6'h2D, 4'h2, 8'h5F);
      branch_to(6'h25, 12'h000);
      asm_pc = sub_c;
      op_const(6'h01, 4'h8, 8'($urandom));
      op_const(6'h0D, 4'h8, 8'h00);
      branch_to(6'h39, 12'h000);                 // return c, not taken
      op_const(6'h2D, 4'h8, 8'h53);
      branch_to(6'h3D, 12'h000);
      op_const(6'h2D, 4'h8, 8'h5E);
      branch_to(6'h25, 12'h000);
      asm_pc = rec;
      branch_to(6'h20, rec);                     // endless recursion
   endtask

   //////////////////////////////
   // instruction-set reference
   function automatic int run_model();
      logic [7:0]  regs [16];
      logic [11:0] stack [$];
      logic [11:0] pc;
      logic [11:0] next;
      logic [17:0] w;
      logic [5:0]  op;
      logic [3:0]  sx;
      logic [7:0]  b;
      logic [7:0]  v;
      logic [7:0]  res;
      logic [8:0]  wide;
      logic [5:0]  n;
      logic        z;
      logic        c;
      logic        cy;
      logic        cn;
      logic        bin;
      logic        take;
      logic        fault;
      int          steps;
      for (int i = 0; i < 16; i++)
         regs[i] = 8'h00;
      pc    = 12'h000;
      z     = 1'b0;
      c     = 1'b0;
      n     = 6'd0;
      steps = 0;
      while (pc != halt_addr && steps < max_steps)
      begin
         w     = rom[pc];
         op    = w[17:12];
         sx    = w[11:8];
         b     = op[0] ? w[7:0] : regs[w[7:4]];
         v     = regs[sx];
         cy    = op[1];
         next  = pc + 12'd1;
         fault = 1'b0;
         steps++;
         case (op[3:2])
            2'd0: take = z;
            2'd1: take = ~z;
            2'd2: take = c;
            default: take = ~c;
         endcase
         if (!op[4])
            take = 1'b1;
         case (op)
            6'h00, 6'h01: regs[sx] = b;
            6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07:
            begin
               res      = (op[2:1] == 2'b01) ? (v & b) : (op[2:1] == 2'b10) ? (v | b) : (v ^ b);
               regs[sx] = res;
               c        = 1'b0;
               z        = (res == 8'h00);
            end
            6'h08, 6'h09:
            begin
               exp_is_out.push_back(1'b0);
               exp_port.push_back(b);
               exp_data.push_back(8'h00);
               regs[sx] = in_seq[n];
               n        = n + 6'd1;
            end
            6'h0C, 6'h0D, 6'h0E, 6'h0F:
            begin
               res = v & b;
               cn  = ^res ^ (cy & c);        // parity
               z   = (res == 8'h00) & (z | ~cy);
               c   = cn;
            end
            6'h10, 6'h11, 6'h12, 6'h13,
            6'h18, 6'h19, 6'h1A, 6'h1B, 6'h1C, 6'h1D, 6'h1E, 6'h1F:
            begin
               if (op[3])
                  wide = {1'b0, v} - {1'b0, b} - {8'h00, cy & c};
               else
                  wide = {1'b0, v} + {1'b0, b} + {8'h00, cy & c};
               res = wide[7:0];
               z   = (res == 8'h00) & (z | ~cy);
               c   = wide[8];
               if (!(op[3] && op[2]))        // compare keeps sx
                  regs[sx] = res;
            end
            6'h14:
            begin
               case (w[2:0])
                  3'h6: bin = 1'b0;
                  3'h7: bin = 1'b1;
                  3'h4: bin = v[0];          // slx, rr
                  3'h0: bin = c;
                  3'h2: bin = v[7];          // rl, srx
                  default: bin = 1'b0;
               endcase
               if (w[3])
               begin
                  cn  = v[0];
                  res = {bin, v[7:1]};
               end
               else
               begin
                  cn  = v[7];
                  res = {v[6:0], bin};
               end
               regs[sx] = res;
               c        = cn;
               z        = (res == 8'h00);
            end
            6'h2C, 6'h2D:
            begin
               exp_is_out.push_back(1'b1);
               exp_port.push_back(b);
               exp_data.push_back(v);
            end
            6'h22, 6'h32, 6'h36, 6'h3A, 6'h3E:
               if (take)
                  next = w[11:0];
            6'h20, 6'h30, 6'h34, 6'h38, 6'h3C:
               if (take)
               begin
                  if (stack.size() == stack_depth)
                     fault = 1'b1;
                  else
                  begin
                     stack.push_back(next);
                     next = w[11:0];
                  end
               end
            6'h25, 6'h31, 6'h35, 6'h39, 6'h3D:
               if (take)
               begin
                  if (stack.size() == 0)
                     fault = 1'b1;
                  else
                     next = stack.pop_back();
               end
            default: ;
         endcase
         if (fault)
         begin
            next = 12'h000;                  // restart keeps registers
            stack.delete();
            z = 1'b0;
            c = 1'b0;
         end
         pc = next;
      end
      if (steps >= max_steps)
      begin
         errors++;
         $display("reference model never reached the final loop");
      end
      return steps;
   endfunction

   //////////////////////////////
   // stimulus on the falling edge
   always @(negedge clk)
   begin
      instruction <= rom[address];
      in_port     <= in_seq[in_idx];
      if (read_strobe)
         in_idx <= in_idx + 6'd1;
   end

   // compare each strobe with the next expected event
   always @(negedge clk)
   begin
      if (!rst && (read_strobe || write_strobe))
      begin
         if (exp_is_out.size() == 0)
         begin
            errors++;
            $display("port strobe at %0t ns with no event left to expect", $time);
         end
         else
         begin
            assert (exp_is_out[0] == write_strobe)
            else
            begin
               errors++;
               $display("[ERROR] %0t ns: strobe kind expected %s got %s", $time,
                        exp_is_out[0] ? "write" : "read", write_strobe ? "write" : "read");
            end
            assert (port_id == exp_port[0])
            else
            begin
               errors++;
               $display("[ERROR] %0t ns: port_id expected %02h got %02h", $time,
                        exp_port[0], port_id);
            end
            if (write_strobe)
               assert (out_port == exp_data[0])
               else
               begin
                  errors++;
                  $display("[ERROR] %0t ns: out_port at port %02h expected %02h got %02h",
                           $time, port_id, exp_data[0], out_port);
               end
            void'(exp_is_out.pop_front());
            void'(exp_port.pop_front());
            void'(exp_data.pop_front());
         end
      end
   end

   //////////////////////////////
   initial
   begin
      clk         = 1'b0;
      rst         = 1'b1;
      instruction = '0;
      in_port     = '0;
      in_idx      = '0;
      errors      = 0;
      cycle_limit = 0;
      void'($urandom(46));
      build_program();
      for (int i = 0; i < 64; i++)
         in_seq[i] = 8'($urandom);
      exec_count  = run_model();
      cycle_limit = 2 * exec_count + 100;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      while (address != halt_addr)
         @(negedge clk);
      repeat (4) @(negedge clk);             // last strobes drain
      if (exp_is_out.size() != 0)
      begin
         errors++;
         $display("final loop reached with %0d expected port events never seen",
                  exp_is_out.size());
      end
      $display("run complete, %0d errors", errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

   // timeout from the model's instruction count
   initial
   begin
      wait (cycle_limit > 0);
      for (int n = 0; n < cycle_limit; n++)
         @(posedge clk);
      $display("timeout, core did not reach its final loop within %0d cycles", cycle_limit);
      $display("run stopped, %0d errors", errors);
      $display("Errors found");
      $finish;
   end

endmodule

// ==== mcu8.f ====
mcu8_pkg.sv
mcu8_sequencer.sv
mcu8_decode.sv
mcu8_regfile.sv
mcu8_execute.sv
mcu8.sv
mcu8_props.sv
mcu8_tb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the mcu8 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   -f mcu8.f \
   --top-module mcu8_tb \
   --Mdir obj_dir \
   -o mcu8_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/mcu8_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^No errors$" sim.log; then
   exit 0
else
   echo "pass message not found in sim.log"
   exit 1
fi
